/* verilog.f */
hw/pkt_buf_pkg.sv
hw/pkt_ram.sv
hw/rx_pkt_writer.sv
hw/pkt_buf_reader.sv
hw/pkt_buf_top.sv
testbench/tb_clk_gen.sv
testbench/pkt_buf_tb.sv

/* Bender.yml */
package:
  name: pkt_buf

sources:
  - files:
      - hw/pkt_buf_pkg.sv
      - hw/pkt_ram.sv
      - hw/rx_pkt_writer.sv
      - hw/pkt_buf_reader.sv
      - hw/pkt_buf_top.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/pkt_buf_tb.sv

/* testbench/pkt_buf_tb.sv */
`timescale 1ns/1ps

module pkt_buf_tb;

    //////////////////////////////////////////////////
    // types and table storage
    //////////////////////////////////////////////////
    typedef enum logic [1:0] {
        RDY_ON,                                   // sink always ready
        RDY_RAND,                                 // coin flip every cycle
        RDY_STALL                                 // long low stretches, shorter high ones
    } ready_mode_e;

    // one expected output beat
    typedef struct packed {
        pkt_buf_pkg::axis_beat_t beat;
        pkt_buf_pkg::pkt_len_t   len;             // expected user field
        logic [7:0]              row;             // table row, for the test name
    } exp_beat_t;

    localparam int MAX_ROWS     = 32;
    localparam int DRAIN_CYCLES = 40;             // quiet time after the last beat

    string       row_name [MAX_ROWS];
    int          row_len  [MAX_ROWS];             // bytes
    int          row_gap  [MAX_ROWS];             // idle cycles after the packet
    ready_mode_e row_mode [MAX_ROWS];
    int          num_rows = 0;

    //////////////////////////////////////////////////
    // dut signals and tb state
    //////////////////////////////////////////////////
    logic                    clk;
    logic                    rst;
    pkt_buf_pkg::axis_beat_t s_beat_i;
    logic                    s_valid_i;
    logic                    s_ready_o;
    pkt_buf_pkg::axis_beat_t m_beat_o;
    pkt_buf_pkg::pkt_len_t   m_len_o;
    logic                    m_valid_o;
    logic                    m_ready_i;

    integer      seed = 53;                       // shared by payload and ready
    exp_beat_t   exp_q [$];
    exp_beat_t   mon_exp;
    ready_mode_e cur_mode;                        // follows the row on the input side
    int          rdy_stretch = 0;
    logic [31:0] rnd;
    int          stall_run   = 0;
    logic        saw_full    = 1'b0;              // input blocked on buffer space
    int          total_beats = 0;
    int          cycle_cnt   = 0;
    int          timeout_limit;

    tb_clk_gen tb_clk_gen_i (
        .clk_o (clk),
        .rst_o (rst)
    );

    pkt_buf_top pkt_buf_top_i (
        .clk       (clk),
        .rst       (rst),
        .s_beat_i  (s_beat_i),
        .s_valid_i (s_valid_i),
        .s_ready_o (s_ready_o),
        .m_beat_o  (m_beat_o),
        .m_len_o   (m_len_o),
        .m_valid_o (m_valid_o),
        .m_ready_i (m_ready_i)
    );

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string test, input string field,
                             input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("error: test %s %s expected 0x%0h actual 0x%0h",
                                test, field, expected, actual));
        end
    endtask

    task automatic add_row(input string name, input int len, input int gap,
                           input ready_mode_e mode);
        row_name[num_rows] = name;
        row_len[num_rows]  = len;
        row_gap[num_rows]  = gap;
        row_mode[num_rows] = mode;
        num_rows++;
    endtask

    // holds the beat until valid and ready meet, returns just after that edge
    task automatic drive_beat(input pkt_buf_pkg::axis_beat_t beat);
        logic acc;
        s_beat_i  = beat;
        s_valid_i = 1'b1;
        do begin
            @(negedge clk);
            acc = s_ready_o;                      // stable half a cycle before the edge
            @(posedge clk);
            #1;
        end while (!acc);
    endtask

    task automatic send_packet(input int row);
        int                      nwords;
        pkt_buf_pkg::axis_beat_t beat;
        exp_beat_t               e;
        nwords = (row_len[row] + 7) / 8;
        for (int w = 0; w < nwords; w++) begin
            beat = '0;                            // bytes past the length stay zero
            for (int b = 0; b < 8; b++) begin
                if (w * 8 + b < row_len[row]) begin
                    rnd                  = $random(seed);
                    beat.data[b*8 +: 8]  = rnd[7:0];
                    beat.strb[b]         = 1'b1;
                end
            end
            beat.last = (w == nwords - 1);
            e.beat    = beat;
            e.len     = pkt_buf_pkg::pkt_len_t'(row_len[row]);
            e.row     = 8'(row);
            exp_q.push_back(e);
            drive_beat(beat);
        end
        s_valid_i = 1'b0;
        repeat (row_gap[row]) begin
            @(posedge clk);
            #1;
        end
    endtask

    //////////////////////////////////////////////////
    // output ready, 2 ns after the edge so the random draws keep one order
    //////////////////////////////////////////////////
    always begin
        @(posedge clk);
        #2;
        case (cur_mode)
            RDY_RAND: begin
                rnd       = $random(seed);
                m_ready_i = rnd[0];
            end
            RDY_STALL: begin
                if (rdy_stretch == 0) begin
                    rnd = $random(seed);
                    if (m_ready_i) begin
                        m_ready_i   = 1'b0;
                        rdy_stretch = 300 + rnd[6:0];   // long enough to fill the buffer
                    end else begin
                        m_ready_i   = 1'b1;
                        rdy_stretch = 100 + rnd[5:0];
                    end
                end else begin
                    rdy_stretch--;
                end
            end
            default: begin
                m_ready_i   = 1'b1;
                rdy_stretch = 0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // monitor, sampled mid-cycle
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rst === 1'b0) begin
            // more than the header cycle means the writer ran out of room
            if (s_valid_i && !s_ready_o) begin
                stall_run++;
                if (stall_run >= 4) saw_full = 1'b1;
            end else begin
                stall_run = 0;
            end

            if (m_valid_o && m_ready_i) begin
                if (exp_q.size() == 0) begin
                    abort_run("output beat arrived with no packet pending");
                end else begin
                    mon_exp = exp_q.pop_front();
                    check_val(row_name[mon_exp.row], "data", mon_exp.beat.data, m_beat_o.data);
                    check_val(row_name[mon_exp.row], "strb", mon_exp.beat.strb, m_beat_o.strb);
                    check_val(row_name[mon_exp.row], "last", mon_exp.beat.last, m_beat_o.last);
                    check_val(row_name[mon_exp.row], "len", mon_exp.len, m_len_o);
                end
            end
        end
    end

    // hard stop
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_limit) begin
            abort_run($sformatf("timeout: packets not drained within %0d cycles",
                                timeout_limit));
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        s_beat_i  = '0;
        s_valid_i = 1'b0;
        m_ready_i = 1'b0;
        cur_mode  = RDY_ON;

        // name, bytes, gap, ready mode
        add_row("aligned_64",   64,   0, RDY_ON);
        add_row("one_word_8",   8,    2, RDY_ON);
        add_row("single_byte",  1,    0, RDY_ON);
        add_row("tail_2",       10,   1, RDY_ON);
        add_row("tail_3",       19,   0, RDY_ON);
        add_row("tail_4",       28,   3, RDY_ON);
        add_row("tail_5",       37,   0, RDY_ON);
        add_row("tail_6",       46,   1, RDY_ON);
        add_row("tail_7",       55,   0, RDY_ON);
        add_row("mtu_1500",     1500, 0, RDY_ON);
        add_row("max_2048",     2048, 4, RDY_ON);
        add_row("rand_100",     100,  1, RDY_RAND);
        add_row("rand_256",     256,  0, RDY_RAND);
        add_row("rand_13",      13,   3, RDY_RAND);
        add_row("rand_1",       1,    0, RDY_RAND);
        add_row("rand_999",     999,  0, RDY_RAND);
        add_row("rand_2048",    2048, 2, RDY_RAND);
        add_row("stall_1024_a", 1024, 0, RDY_STALL);
        add_row("stall_1024_b", 1024, 0, RDY_STALL);
        add_row("stall_1024_c", 1024, 0, RDY_STALL);
        add_row("stall_1024_d", 1024, 0, RDY_STALL);
        add_row("stall_2048",   2048, 0, RDY_STALL);
        add_row("stall_7",      7,    0, RDY_STALL);
        add_row("wrap_1600",    1600, 0, RDY_ON);
        add_row("wrap_17",      17,   5, RDY_ON);

        for (int i = 0; i < num_rows; i++) total_beats += (row_len[i] + 7) / 8;
        timeout_limit = 4 * (total_beats + num_rows) + 2000;   // headers count as words

        wait (rst === 1'b0);
        @(negedge clk);
        check_val("reset", "m_valid", 1'b0, m_valid_o);
        check_val("reset", "s_ready", 1'b0, s_ready_o);
        while (s_ready_o !== 1'b1) @(negedge clk);
        check_val("reset", "m_valid", 1'b0, m_valid_o);

        @(posedge clk);
        #1;
        for (int row = 0; row < num_rows; row++) begin
            cur_mode = row_mode[row];
            send_packet(row);
        end

        while (exp_q.size() != 0) @(negedge clk);
        repeat (DRAIN_CYCLES) @(negedge clk);     // any stray beat trips the monitor
        check_val("stall_rows", "input_blocked", 1'b1, saw_full);

        if (m_valid_o === 1'b0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            abort_run("output valid still high after the last packet was drained");
        end
    end

endmodule

/* testbench/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    localparam int HALF_PERIOD_NS = 4;            // 8 ns clock
    localparam int RST_CYCLES     = 2;

    // free running clock
    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // reset held over the first two rising edges, released just after
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_o = 1'b0;
    end

endmodule

/* hw/pkt_buf_top.sv */
`timescale 1ns/1ps

module pkt_buf_top (
    input  logic                    clk,
    input  logic                    rst,

    // receive stream in
    input  pkt_buf_pkg::axis_beat_t s_beat_i,
    input  logic                    s_valid_i,
    output logic                    s_ready_o,

    // stream out with length in the user field
    output pkt_buf_pkg::axis_beat_t m_beat_o,
    output pkt_buf_pkg::pkt_len_t   m_len_o,
    output logic                    m_valid_o,
    input  logic                    m_ready_i
);

    //////////////////////////////////////////////////
    // internal wires
    //////////////////////////////////////////////////
    pkt_buf_pkg::buf_ptr_t          committed_prod;   // writer to reader
    pkt_buf_pkg::buf_ptr_t          committed_cons;   // reader to writer
    logic                           wr_en;
    pkt_buf_pkg::buf_addr_t         wr_addr;
    logic [pkt_buf_pkg::DATA_W-1:0] wr_data;
    pkt_buf_pkg::buf_addr_t         rd_addr;
    logic [pkt_buf_pkg::DATA_W-1:0] rd_data;

    rx_pkt_writer rx_pkt_writer_i (
        .clk              (clk),
        .rst              (rst),
        .s_beat_i         (s_beat_i),
        .s_valid_i        (s_valid_i),
        .s_ready_o        (s_ready_o),
        .committed_cons_i (committed_cons),
        .committed_prod_o (committed_prod),
        .wr_en_o          (wr_en),
        .wr_addr_o        (wr_addr),
        .wr_data_o        (wr_data)
    );

    pkt_ram pkt_ram_i (
        .clk       (clk),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

    pkt_buf_reader pkt_buf_reader_i (
        .clk              (clk),
        .rst              (rst),
        .committed_prod_i (committed_prod),
        .committed_cons_o (committed_cons),
        .rd_addr_o        (rd_addr),
        .rd_data_i        (rd_data),
        .m_beat_o         (m_beat_o),
        .m_len_o          (m_len_o),
        .m_valid_o        (m_valid_o),
        .m_ready_i        (m_ready_i)
    );

endmodule

/* hw/pkt_buf_reader.sv */
`timescale 1ns/1ps

module pkt_buf_reader (
    input  logic                           clk,
    input  logic                           rst,

    // pointer exchange with the writer
    input  pkt_buf_pkg::buf_ptr_t          committed_prod_i,
    output pkt_buf_pkg::buf_ptr_t          committed_cons_o,

    // buffer read port
    output pkt_buf_pkg::buf_addr_t         rd_addr_o,
    input  logic [pkt_buf_pkg::DATA_W-1:0] rd_data_i,

    // output stream
    output pkt_buf_pkg::axis_beat_t        m_beat_o,
    output pkt_buf_pkg::pkt_len_t          m_len_o,
    output logic                           m_valid_o,
    input  logic                           m_ready_i
);

    //////////////////////////////////////////////////
    // local state
    //////////////////////////////////////////////////
    pkt_buf_pkg::rd_state_e  state;
    pkt_buf_pkg::buf_ptr_t   rd_ptr;              // next word to fetch
    pkt_buf_pkg::buf_ptr_t   diff;                // committed but unread words

    // data words not yet loaded into the output register
    logic [pkt_buf_pkg::LEN_W-pkt_buf_pkg::BYTE_SEL_W:0] words_left;
    logic [pkt_buf_pkg::STRB_W-1:0]                      last_strb;
    logic [pkt_buf_pkg::DATA_W-1:0]                      hold_data;   // word parked on stall
    logic [pkt_buf_pkg::DATA_W-1:0]                      next_word;

    // header decode, meaningful in RD_HDR only
    pkt_buf_pkg::pkt_len_t                               hdr_len;
    logic [pkt_buf_pkg::LEN_W-pkt_buf_pkg::BYTE_SEL_W:0] hdr_words;
    logic [pkt_buf_pkg::STRB_W-1:0]                      hdr_strb;

    logic                                                ld_beat;
    logic                                                ld_last;

    // the read pointer doubles as the consumer pointer
    assign rd_addr_o        = rd_ptr[pkt_buf_pkg::BUF_AW-1:0];
    assign committed_cons_o = rd_ptr;

    //////////////////////////////////////////////////
    // header decode
    //////////////////////////////////////////////////
    always_comb begin
        hdr_len   = rd_data_i[pkt_buf_pkg::HDR_LEN_LSB +: pkt_buf_pkg::LEN_W];
        // words = len / 8 rounded up
        hdr_words = {1'b0, hdr_len[pkt_buf_pkg::LEN_W-1:pkt_buf_pkg::BYTE_SEL_W]};
        hdr_strb  = '1;                           // full last word by default
        if (|hdr_len[pkt_buf_pkg::BYTE_SEL_W-1:0]) begin
            hdr_words = hdr_words + 1'b1;
            // low-order ones, as many as len mod 8
            hdr_strb  = ~({pkt_buf_pkg::STRB_W{1'b1}} <<
                          hdr_len[pkt_buf_pkg::BYTE_SEL_W-1:0]);
        end
    end

    //////////////////////////////////////////////////
    // beat source select
    //////////////////////////////////////////////////
    // replay the parked word after a stall, else take the ram output
    assign next_word = (state == pkt_buf_pkg::RD_HOLD) ? hold_data : rd_data_i;

    // output register free in RD_FIRST, otherwise only on a transfer
    always_comb begin
        ld_beat = 1'b0;
        case (state)
            pkt_buf_pkg::RD_FIRST:  ld_beat = 1'b1;
            pkt_buf_pkg::RD_STREAM: ld_beat = m_ready_i;
            pkt_buf_pkg::RD_HOLD:   ld_beat = m_ready_i;
            default:                ld_beat = 1'b0;
        endcase
    end

    assign ld_last = (words_left == 1);           // word being loaded ends the packet

    //////////////////////////////////////////////////
    // sender fsm
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= pkt_buf_pkg::RD_IDLE;
            rd_ptr    <= '0;
            diff      <= '0;
            m_valid_o <= 1'b0;
        end else begin
            diff <= committed_prod_i - rd_ptr;    // wrap bit keeps it exact

            case (state)
                pkt_buf_pkg::RD_IDLE: begin
                    // header slot is already on the read address
                    if (diff != '0) begin
                        rd_ptr <= rd_ptr + 1'b1;
                        state  <= pkt_buf_pkg::RD_HDR;
                    end
                end

                pkt_buf_pkg::RD_HDR: begin
                    m_len_o    <= hdr_len;        // user field for every beat
                    words_left <= hdr_words;
                    last_strb  <= hdr_strb;
                    rd_ptr     <= rd_ptr + 1'b1;  // fetch first data word
                    state      <= pkt_buf_pkg::RD_FIRST;
                end

                pkt_buf_pkg::RD_FIRST,
                pkt_buf_pkg::RD_STREAM,
                pkt_buf_pkg::RD_HOLD: begin
                    if (ld_beat) begin
                        m_valid_o  <= 1'b1;
                        words_left <= words_left - 1'b1;
                        if (ld_last) begin
                            // pointer stays on the next header slot
                            state <= pkt_buf_pkg::RD_LAST;
                        end else begin
                            rd_ptr <= rd_ptr + 1'b1;
                            state  <= pkt_buf_pkg::RD_STREAM;
                        end
                    end else if (state == pkt_buf_pkg::RD_STREAM) begin
                        state <= pkt_buf_pkg::RD_HOLD;   // park the fetched word
                    end
                end

                pkt_buf_pkg::RD_LAST: begin
                    if (m_ready_i) begin
                        m_valid_o <= 1'b0;
                        // next packet already committed, skip idle
                        if (diff != '0) begin
                            rd_ptr <= rd_ptr + 1'b1;
                            state  <= pkt_buf_pkg::RD_HDR;
                        end else begin
                            state <= pkt_buf_pkg::RD_IDLE;
                        end
                    end
                end

                default: begin
                    state <= pkt_buf_pkg::RD_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // output beat and hold register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (ld_beat) begin
            m_beat_o.data <= next_word;
            m_beat_o.strb <= ld_last ? last_strb : '1;
            m_beat_o.last <= ld_last;
        end
        if (state == pkt_buf_pkg::RD_STREAM && !m_ready_i) begin
            hold_data <= rd_data_i;               // ram moves on, keep this one
        end
    end

endmodule

/* hw/rx_pkt_writer.sv */
`timescale 1ns/1ps

module rx_pkt_writer (
    input  logic                           clk,
    input  logic                           rst,

    // input stream
    input  pkt_buf_pkg::axis_beat_t        s_beat_i,
    input  logic                           s_valid_i,
    output logic                           s_ready_o,

    // pointer exchange with the reader
    input  pkt_buf_pkg::buf_ptr_t          committed_cons_i,
    output pkt_buf_pkg::buf_ptr_t          committed_prod_o,

    // buffer write port
    output logic                           wr_en_o,
    output pkt_buf_pkg::buf_addr_t         wr_addr_o,
    output logic [pkt_buf_pkg::DATA_W-1:0] wr_data_o
);

    //////////////////////////////////////////////////
    // local state
    //////////////////////////////////////////////////
    pkt_buf_pkg::buf_ptr_t          wr_ptr;       // next data slot
    pkt_buf_pkg::buf_ptr_t          hdr_ptr;      // header slot of the current packet
    pkt_buf_pkg::buf_ptr_t          used_words;
    pkt_buf_pkg::buf_ptr_t          free_words;
    pkt_buf_pkg::pkt_len_t          byte_cnt;     // running byte count
    pkt_buf_pkg::pkt_len_t          beat_bytes;
    logic                           in_pkt;       // first beat already taken
    logic                           hdr_wr;       // header write cycle
    logic                           commit_pend;
    logic                           room_ok;      // enough space for a max packet
    logic                           beat_xfer;
    logic [pkt_buf_pkg::DATA_W-1:0] hdr_word;

    //////////////////////////////////////////////////
    // handshake and space
    //////////////////////////////////////////////////
    // mid-packet beats never wait on space, it was checked at the start
    assign s_ready_o = !hdr_wr && (in_pkt || room_ok);
    assign beat_xfer = s_valid_i && s_ready_o;

    // bytes carried by this beat
    assign beat_bytes = pkt_buf_pkg::pkt_len_t'($countones(s_beat_i.strb));

    // wrap bit makes the subtraction exact, header slot counted as used
    // in the header cycle wr_ptr still sits on the next header slot
    assign used_words = wr_ptr + hdr_wr - committed_cons_i;
    assign free_words = pkt_buf_pkg::buf_ptr_t'(pkt_buf_pkg::BUF_DEPTH) - used_words;

    // header word, length field only
    always_comb begin
        hdr_word = '0;
        hdr_word[pkt_buf_pkg::HDR_LEN_LSB +: pkt_buf_pkg::LEN_W] = byte_cnt;
    end

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr           <= pkt_buf_pkg::buf_ptr_t'(1);  // slot 0 kept for the header
            hdr_ptr          <= '0;
            in_pkt           <= 1'b0;
            hdr_wr           <= 1'b0;
            commit_pend      <= 1'b0;
            room_ok          <= 1'b0;
            wr_en_o          <= 1'b0;
            committed_prod_o <= '0;
        end else begin
            // registered, lags the pointers by a cycle which only underestimates space
            room_ok <= (free_words >=
                        pkt_buf_pkg::buf_ptr_t'(pkt_buf_pkg::MAX_PKT_WORDS + 1));
            wr_en_o     <= 1'b0;
            commit_pend <= 1'b0;

            if (beat_xfer) begin
                wr_en_o <= 1'b1;
                wr_ptr  <= wr_ptr + 1'b1;
                in_pkt  <= !s_beat_i.last;
                hdr_wr  <= s_beat_i.last;        // header goes out next cycle
            end

            // header cycle, input held off
            if (hdr_wr) begin
                wr_en_o     <= 1'b1;
                hdr_ptr     <= wr_ptr;           // next packet header slot
                wr_ptr      <= wr_ptr + 1'b1;    // its first data slot
                hdr_wr      <= 1'b0;
                commit_pend <= 1'b1;
            end

            // publish once the header has landed in the ram
            if (commit_pend) begin
                committed_prod_o <= hdr_ptr;
            end
        end
    end

    //////////////////////////////////////////////////
    // write data path
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (beat_xfer) begin
            wr_addr_o <= wr_ptr[pkt_buf_pkg::BUF_AW-1:0];
            wr_data_o <= s_beat_i.data;
            byte_cnt  <= in_pkt ? byte_cnt + beat_bytes : beat_bytes;
        end else if (hdr_wr) begin
            wr_addr_o <= hdr_ptr[pkt_buf_pkg::BUF_AW-1:0];
            wr_data_o <= hdr_word;
        end
    end

endmodule

/* hw/pkt_ram.sv */
`timescale 1ns/1ps

module pkt_ram (
    input  logic                           clk,

    // write side, driven by the writer
    input  logic                           wr_en_i,
    input  pkt_buf_pkg::buf_addr_t         wr_addr_i,
    input  logic [pkt_buf_pkg::DATA_W-1:0] wr_data_i,

    // read side, driven by the reader
    input  pkt_buf_pkg::buf_addr_t         rd_addr_i,
    output logic [pkt_buf_pkg::DATA_W-1:0] rd_data_o
);

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////
    logic [pkt_buf_pkg::DATA_W-1:0] mem [pkt_buf_pkg::BUF_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, data one cycle after the address
    // same-address collision returns the old word
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

/* hw/pkt_buf_pkg.sv */
package pkt_buf_pkg;

    //////////////////////////////////////////////////
    // datapath geometry
    //////////////////////////////////////////////////
    localparam int DATA_W     = 64;               // one buffer word per beat
    localparam int STRB_W     = DATA_W / 8;       // byte enables per beat
    localparam int BYTE_SEL_W = $clog2(STRB_W);   // byte offset bits inside a word
    localparam int LEN_W      = 16;               // byte length field

    //////////////////////////////////////////////////
    // buffer geometry
    //////////////////////////////////////////////////
    localparam int BUF_AW    = 9;
    localparam int BUF_DEPTH = 2 ** BUF_AW;       // 512 words

    // largest packet accepted, well under the buffer size
    localparam int MAX_PKT_BYTES = 2048;
    localparam int MAX_PKT_WORDS = MAX_PKT_BYTES / STRB_W;

    // length sits in bits 47:32 of the header word
    localparam int HDR_LEN_LSB = 32;

    //////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////
    typedef logic [BUF_AW-1:0] buf_addr_t;        // word address into the buffer
    typedef logic [BUF_AW:0]   buf_ptr_t;         // msb is the wrap bit
    typedef logic [LEN_W-1:0]  pkt_len_t;         // packet length in bytes

    // one stream beat, same layout on both ports
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;                  // contiguous low-order on last beat
        logic              last;
    } axis_beat_t;

    // reader (sender) fsm
    typedef enum logic [2:0] {
        RD_IDLE,                                  // waiting on a committed packet
        RD_HDR,                                   // header word on read data
        RD_FIRST,                                 // first data word on read data
        RD_STREAM,                                // streaming straight from the ram
        RD_HOLD,                                  // replaying the captured word
        RD_LAST                                   // last beat waiting on ready
    } rd_state_e;

endpackage
